// ==== adcPkg.sv ====
package adcPkg;

	//////////////////////////////////////////////////
	// widths and serial timing
	localparam int codeWidth = 12;
	localparam int sumWidth = 16;
	localparam int frameBits = 16;
	localparam int sclkHalfCycles = 2;	// clk cycles per sclk half period
	localparam int halfCntWidth = $clog2(sclkHalfCycles);
	localparam int edgeCntWidth = $clog2(2 * frameBits);	// sclk edges per frame

	//////////////////////////////////////////////////
	// sample and filter sequencing
	localparam int framesPerSample = 5;
	localparam int currentFrames = 3;
	localparam int frameIdxWidth = $clog2(framesPerSample);
	localparam int sampleCount = 10;
	localparam int sampleCntWidth = $clog2(sampleCount);
	localparam int meanShift = 3;	// divide by 8 after trimming two samples
	localparam int resultFields = 2;	// current and resistance

	typedef logic [codeWidth-1:0] adcCode;
	typedef logic [2:0] adcChannel;
	typedef logic [sumWidth-1:0] filterSum;

	typedef struct packed
	{
		adcCode current;
		adcCode resistance;
	} measResult;

	localparam adcChannel currentChannel = 3'd1;
	localparam adcChannel resistanceChannel = 3'd0;

	// plausibility window for the current code
	localparam adcCode codeHighLimit = 12'd4000;
	localparam adcCode codeLowLimit = 12'd98;
	localparam adcCode zeroCurrentCode = 12'h809;	// code at zero load current
	localparam adcCode fallbackCode = 12'd1950;

	typedef enum logic [1:0] {spiIdle, spiShift, spiDone} spiState;

	typedef enum logic [2:0]
	{
		seqIdle, seqFrame, seqWait, seqScale, seqReport
	} seqState;

	typedef enum logic [2:0]
	{
		filtIdle, filtRequest, filtWait, filtAccumulate, filtTrim, filtOutput
	} filterState;

endpackage

// ==== adcSpiMaster.sv ====
module adcSpiMaster (
	input  logic clk,
	input  logic rst_n,
	input  logic frameStart,
	input  adcPkg::adcChannel frameChannel,
	input  logic dout,
	output logic sclk,
	output logic din,
	output logic frameDone,
	output adcPkg::adcCode frameData
);
	import adcPkg::*;

	spiState state;
	logic [halfCntWidth-1:0] halfCnt;	// clk cycles inside one sclk half
	logic [edgeCntWidth-1:0] edgeCnt;	// sclk edges done so far
	logic [edgeCntWidth-2:0] fallIdx;	// index of the coming falling edge
	logic halfEnd;
	logic lastEdge;
	adcCode shiftReg;

	assign halfEnd = (halfCnt == halfCntWidth'(sclkHalfCycles - 1));
	assign lastEdge = (edgeCnt == edgeCntWidth'(2 * frameBits - 1));
	assign fallIdx = edgeCnt[edgeCntWidth-1:1];
	assign frameDone = (state == spiDone);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= spiIdle;
			halfCnt <= '0;
			edgeCnt <= '0;
			sclk <= 1'b1;	// idles high
			din <= 1'b0;
		end
		else
		begin
			case (state)
				spiIdle:
				begin
					if (frameStart)
					begin
						halfCnt <= halfCntWidth'(1);	// start cycle is the first half cycle
						edgeCnt <= '0;
						state <= spiShift;
					end
				end
				spiShift:
				begin
					if (!halfEnd)
						halfCnt <= halfCnt + 1'b1;
					else
					begin
						halfCnt <= '0;
						sclk <= ~sclk;
						edgeCnt <= edgeCnt + 1'b1;
						if (sclk)
						begin
							// address bits go out on falling edges 3 to 5
							case (fallIdx)
								2: din <= frameChannel[2];
								3: din <= frameChannel[1];
								4: din <= frameChannel[0];
								default: din <= 1'b0;
							endcase
						end
						else if (lastEdge)
							state <= spiDone;	// 16th rising edge
					end
				end
				spiDone:
					state <= spiIdle;
				default:
					state <= spiIdle;
			endcase
		end
	end

	// dout is taken on every rising edge and the last 12 bits are the code
	always_ff @(posedge clk)
	begin
		if (state == spiShift && halfEnd && !sclk)
		begin
			shiftReg <= {shiftReg[codeWidth-2:0], dout};
			if (lastEdge)
				frameData <= {shiftReg[codeWidth-2:0], dout};
		end
	end

endmodule

// ==== conversionSequencer.sv ====
module conversionSequencer (
	input  logic clk,
	input  logic rst_n,
	input  logic sampleStart,
	input  logic frameDone,
	input  adcPkg::adcCode frameData,
	input  logic scaledValid,
	input  adcPkg::adcCode scaledCurrent,
	output logic csN,
	output logic frameStart,
	output adcPkg::adcChannel frameChannel,
	output logic scaleStart,
	output adcPkg::adcCode [adcPkg::currentFrames-1:0] currentCodes,
	output adcPkg::measResult sample,
	output logic sampleValid
);
	import adcPkg::*;

	seqState state;
	logic [frameIdxWidth-1:0] frameIdx;	// frame inside the burst
	logic lastFrame;

	assign lastFrame = (frameIdx == frameIdxWidth'(framesPerSample - 1));
	assign frameStart = (state == seqFrame);
	assign scaleStart = (state == seqScale);

	// the converter answers one frame late, so the address runs one frame ahead
	assign frameChannel = (frameIdx < frameIdxWidth'(currentFrames)) ? currentChannel
		: resistanceChannel;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= seqIdle;
			frameIdx <= '0;
			csN <= 1'b1;
			sampleValid <= 1'b0;
		end
		else
		begin
			sampleValid <= 1'b0;
			case (state)
				seqIdle:
				begin
					if (sampleStart)
					begin
						csN <= 1'b0;	// held low over all five frames
						frameIdx <= '0;
						state <= seqFrame;
					end
				end
				seqFrame:
					state <= seqWait;
				seqWait:
				begin
					if (frameDone)
					begin
						if (lastFrame)
							state <= seqScale;
						else
						begin
							frameIdx <= frameIdx + 1'b1;
							state <= seqFrame;
						end
					end
				end
				seqScale:
					state <= seqReport;
				seqReport:
				begin
					if (scaledValid)
					begin
						sampleValid <= 1'b1;
						csN <= 1'b1;
						state <= seqIdle;
					end
				end
				default:
					state <= seqIdle;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// frame data capture
	always_ff @(posedge clk)
	begin
		if (state == seqWait && frameDone)
		begin
			if (lastFrame)
				sample.resistance <= frameData;
			else if (frameIdx != '0)	// first frame carries stale data
				currentCodes <= {currentCodes[currentFrames-2:0], frameData};
		end
		if (state == seqReport && scaledValid)
			sample.current <= scaledCurrent;
	end

endmodule

// ==== currentScaler.sv ====
module currentScaler (
	input  logic clk,
	input  logic rst_n,
	input  logic scaleStart,
	input  adcPkg::adcCode [adcPkg::currentFrames-1:0] currentCodes,
	output logic scaledValid,
	output adcPkg::adcCode scaledCurrent
);
	import adcPkg::*;

	adcCode medianCode;
	logic medianValid;

	function automatic adcCode median3(input adcCode a, input adcCode b, input adcCode c);
		adcCode lo;
		adcCode hi;
		adcCode mid;
		lo = (a < b) ? a : b;
		hi = (a < b) ? b : a;
		mid = (hi < c) ? hi : c;
		return (lo > mid) ? lo : mid;
	endfunction

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			medianValid <= 1'b0;
			scaledValid <= 1'b0;
		end
		else
		begin
			medianValid <= scaleStart;
			scaledValid <= medianValid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (scaleStart)
			medianCode <= median3(currentCodes[0], currentCodes[1], currentCodes[2]);
		if (medianValid)
		begin
			if (medianCode >= codeHighLimit || medianCode <= codeLowLimit)
				scaledCurrent <= fallbackCode;	// implausible reading
			else if (medianCode >= zeroCurrentCode)
				scaledCurrent <= medianCode - zeroCurrentCode;
			else
				scaledCurrent <= zeroCurrentCode - medianCode;	// magnitude only
		end
	end

endmodule

// ==== trimmedMeanFilter.sv ====
module trimmedMeanFilter (
	input  logic clk,
	input  logic rst_n,
	input  logic measStart,
	input  logic sampleValid,
	input  adcPkg::measResult sample,
	output logic sampleStart,
	output adcPkg::measResult result,
	output logic resultValid
);
	import adcPkg::*;

	filterState state;
	logic [sampleCntWidth-1:0] sampleCnt;
	logic lastSample;
	logic [resultFields-1:0][codeWidth-1:0] sampleCodes;	// latched sample
	logic [resultFields-1:0][codeWidth-1:0] meanCodes;
	filterSum sum [resultFields];
	adcCode maxCode [resultFields];
	adcCode minCode [resultFields];

	assign sampleStart = (state == filtRequest);
	assign lastSample = (sampleCnt == sampleCntWidth'(sampleCount - 1));

	always_comb
	begin
		for (int i = 0; i < resultFields; i++)
			meanCodes[i] = codeWidth'(sum[i] >> meanShift);
	end

	//////////////////////////////////////////////////
	// control cycle
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= filtIdle;
			sampleCnt <= '0;
			result <= '0;
			resultValid <= 1'b0;
		end
		else
		begin
			resultValid <= 1'b0;
			case (state)
				filtIdle:
				begin
					if (measStart)
					begin
						sampleCnt <= '0;
						state <= filtRequest;
					end
				end
				filtRequest:
					state <= filtWait;
				filtWait:
					if (sampleValid)
						state <= filtAccumulate;
				filtAccumulate:
				begin
					if (lastSample)
						state <= filtTrim;
					else
					begin
						sampleCnt <= sampleCnt + 1'b1;
						state <= filtRequest;
					end
				end
				filtTrim:
					state <= filtOutput;
				filtOutput:
				begin
					result <= meanCodes;	// current in the upper field
					resultValid <= 1'b1;
					state <= filtIdle;
				end
				default:
					state <= filtIdle;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// running sum and extremes per field
	always_ff @(posedge clk)
	begin
		if (state == filtWait && sampleValid)
			sampleCodes <= sample;
		for (int i = 0; i < resultFields; i++)
		begin
			if (state == filtIdle && measStart)
				sum[i] <= '0;
			else if (state == filtAccumulate)
			begin
				sum[i] <= sum[i] + filterSum'(sampleCodes[i]);
				if (sampleCnt == '0 || sampleCodes[i] > maxCode[i])
					maxCode[i] <= sampleCodes[i];	// first sample seeds both
				if (sampleCnt == '0 || sampleCodes[i] < minCode[i])
					minCode[i] <= sampleCodes[i];
			end
			else if (state == filtTrim)
				sum[i] <= sum[i] - filterSum'(maxCode[i]) - filterSum'(minCode[i]);
		end
	end

endmodule

// ==== adcSampleTop.sv ====
module adcSampleTop (
	input  logic clk,
	input  logic rst_n,
	input  logic measStart,
	input  logic dout,
	output logic sclk,
	output logic din,
	output logic csN,
	output adcPkg::measResult result,
	output logic resultValid
);
	import adcPkg::*;

	logic sampleStart;
	logic sampleValid;
	measResult sample;
	logic frameStart;
	logic frameDone;
	adcChannel frameChannel;
	adcCode frameData;
	logic scaleStart;
	logic scaledValid;
	adcCode scaledCurrent;
	adcCode [currentFrames-1:0] currentCodes;

	trimmedMeanFilter trimmedMeanFilter_inst (
		.clk(clk),
		.rst_n(rst_n),
		.measStart(measStart),
		.sampleValid(sampleValid),
		.sample(sample),
		.sampleStart(sampleStart),
		.result(result),
		.resultValid(resultValid)
	);

	conversionSequencer conversionSequencer_inst (
		.clk(clk),
		.rst_n(rst_n),
		.sampleStart(sampleStart),
		.frameDone(frameDone),
		.frameData(frameData),
		.scaledValid(scaledValid),
		.scaledCurrent(scaledCurrent),
		.csN(csN),
		.frameStart(frameStart),
		.frameChannel(frameChannel),
		.scaleStart(scaleStart),
		.currentCodes(currentCodes),
		.sample(sample),
		.sampleValid(sampleValid)
	);

	currentScaler currentScaler_inst (
		.clk(clk),
		.rst_n(rst_n),
		.scaleStart(scaleStart),
		.currentCodes(currentCodes),
		.scaledValid(scaledValid),
		.scaledCurrent(scaledCurrent)
	);

	adcSpiMaster adcSpiMaster_inst (
		.clk(clk),
		.rst_n(rst_n),
		.frameStart(frameStart),
		.frameChannel(frameChannel),
		.dout(dout),
		.sclk(sclk),
		.din(din),
		.frameDone(frameDone),
		.frameData(frameData)
	);

endmodule

// ==== adcModel.sv ====
module adcModel (
	input  logic csN,
	input  logic sclk,
	input  logic din,
	output logic dout
);
	timeunit 1ns;
	timeprecision 1ps;
	import adcPkg::*;

	adcCode currentQueue[$];	// filled by the testbench
	adcCode resistanceCode;
	adcChannel addrLog[$];	// address of every frame
	int burstLog[$];	// frames seen per csN low window
	int underflows;

	logic inBurst;
	int fallCnt;
	int riseCnt;
	int frameCnt;
	adcChannel curAddr;
	adcChannel prevAddr;	// address of the frame before this one
	logic [frameBits-1:0] txWord;

	initial
	begin
		dout = 1'b0;
		inBurst = 1'b0;
		fallCnt = 0;
		riseCnt = 0;
		frameCnt = 0;
		curAddr = '0;
		prevAddr = resistanceChannel;
		resistanceCode = '0;
		underflows = 0;
		txWord = '0;
	end

	always @(negedge csN)
	begin
		inBurst = 1'b1;
		fallCnt = 0;
		riseCnt = 0;
		frameCnt = 0;
	end

	always @(posedge csN)
	begin
		if (inBurst)
			burstLog.push_back(frameCnt);
		inBurst = 1'b0;
	end

	// address bits are taken on rising edges 3 to 5 of the frame
	always @(posedge sclk)
	begin
		if (inBurst)
		begin
			if (riseCnt >= 2 && riseCnt <= 4)
				curAddr = {curAddr[1:0], din};
			if (riseCnt == frameBits - 1)
			begin
				addrLog.push_back(curAddr);
				prevAddr = curAddr;
				frameCnt++;
				riseCnt = 0;
			end
			else
				riseCnt++;
		end
	end

	//////////////////////////////////////////////////
	// answer with the code of the previous address
	always @(negedge sclk)
	begin
		if (inBurst)
		begin
			if (fallCnt == 0)
			begin
				if (prevAddr != currentChannel)
					txWord = {4'b0, resistanceCode};
				else if (currentQueue.size() == 0)
				begin
					underflows++;	// testbench gave too few codes
					txWord = '0;
				end
				else
					txWord = {4'b0, currentQueue.pop_front()};
			end
			dout <= txWord[frameBits-1-fallCnt];	// code sits in frame bits 4 to 15
			fallCnt = (fallCnt == frameBits - 1) ? 0 : fallCnt + 1;
		end
	end

endmodule

// ==== tbAdcSampleTop.sv ====
module tbAdcSampleTop;
	timeunit 1ns;
	timeprecision 1ps;
	import adcPkg::*;

	localparam int resultTimeout = 8000;	// clk cycles for one control cycle
	localparam int codesPerCycle = sampleCount * currentFrames;

	logic clk;
	logic rst_n;
	logic measStart;
	logic dout;
	logic sclk;
	logic din;
	logic csN;
	measResult result;
	logic resultValid;

	int seed;
	int errorCount;
	int checkCount;
	int testCount;
	int errStart;
	int codeSet[codesPerCycle];
	int expFirst;
	int expSecond;
	logic seen;

	adcSampleTop adcSampleTop_inst (
		.clk(clk),
		.rst_n(rst_n),
		.measStart(measStart),
		.dout(dout),
		.sclk(sclk),
		.din(din),
		.csN(csN),
		.result(result),
		.resultValid(resultValid)
	);

	adcModel adcModel_inst (
		.csN(csN),
		.sclk(sclk),
		.din(din),
		.dout(dout)
	);

	always #2 clk = ~clk;

	//////////////////////////////////////////////////
	// expected values
	function automatic int medianOf(input int a, input int b, input int c);
		int hi;
		int lo;
		hi = (a > b) ? a : b;
		hi = (hi > c) ? hi : c;
		lo = (a < b) ? a : b;
		lo = (lo < c) ? lo : c;
		return a + b + c - hi - lo;
	endfunction

	function automatic int offsetCorrect(input int code);
		if (code >= int'(codeHighLimit) || code <= int'(codeLowLimit))
			return int'(fallbackCode);
		if (code > int'(zeroCurrentCode))
			return code - int'(zeroCurrentCode);
		return int'(zeroCurrentCode) - code;
	endfunction

	function automatic int trimmedMean(input int vals[sampleCount]);
		int sum;
		int hi;
		int lo;
		sum = 0;
		hi = vals[0];
		lo = vals[0];
		foreach (vals[i])
		begin
			sum += vals[i];
			if (vals[i] > hi)
				hi = vals[i];
			if (vals[i] < lo)
				lo = vals[i];
		end
		return (sum - hi - lo) / (1 << meanShift);
	endfunction

	function automatic int expectedCurrent();
		int samples[sampleCount];
		for (int i = 0; i < sampleCount; i++)
			samples[i] = offsetCorrect(medianOf(codeSet[3*i], codeSet[3*i+1], codeSet[3*i+2]));
		return trimmedMean(samples);
	endfunction

	function automatic int expectedResistance(input int resCode);
		int samples[sampleCount];
		foreach (samples[i])
			samples[i] = resCode;
		return trimmedMean(samples);
	endfunction

	//////////////////////////////////////////////////
	// checks and stimulus
	task automatic compareValue(input string name, input int got, input int expected);
		checkCount++;
		assert (got == expected)
		else
		begin
			$display("ERROR %0t %s: got %0d expected %0d", $time, name, got, expected);
			errorCount++;
		end
	endtask

	task automatic finishTest(input string name);
		testCount++;
		if (errorCount == errStart)
			$display("test %0d %s: passed", testCount, name);
		else
			$display("test %0d %s: %0d errors", testCount, name, errorCount - errStart);
		errStart = errorCount;
	endtask

	task automatic fillRandom(input int lo, input int hi);
		foreach (codeSet[i])
			codeSet[i] = lo + {$random(seed)} % (hi - lo + 1);
	endtask

	task automatic fillOutOfRange();
		foreach (codeSet[i])
		begin
			if ($random(seed) & 1)
				codeSet[i] = 4000 + {$random(seed)} % 96;	// 4000 to 4095
			else
				codeSet[i] = {$random(seed)} % 99;	// 0 to 98
		end
	endtask

	task automatic loadCodes();
		foreach (codeSet[i])
			adcModel_inst.currentQueue.push_back(adcCode'(codeSet[i]));
	endtask

	task automatic waitResult(output logic found);
		int cycles;
		found = 1'b0;
		cycles = 0;
		while (!found && cycles < resultTimeout)
		begin
			@(negedge clk);
			cycles++;
			if (resultValid)
				found = 1'b1;
		end
		if (!found)
		begin
			$display("timeout: no resultValid within %0d clk cycles", resultTimeout);
			errorCount++;
		end
	endtask

	task automatic checkResult(input int expCurrent, input int expResistance);
		compareValue("result.current", int'(result.current), expCurrent);
		compareValue("result.resistance", int'(result.resistance), expResistance);
	endtask

	task automatic runControlCycle(input int expCurrent, input int resCode);
		logic found;
		adcModel_inst.resistanceCode = adcCode'(resCode);
		loadCodes();
		@(negedge clk);
		measStart = 1'b1;
		@(negedge clk);
		measStart = 1'b0;
		waitResult(found);
		if (found)
			checkResult(expCurrent, expectedResistance(resCode));
	endtask

	// every sample is three current frames then two resistance frames
	task automatic checkFrameOrder();
		int expAddr;
		compareValue("frames modulo sample", adcModel_inst.addrLog.size() % framesPerSample, 0);
		foreach (adcModel_inst.addrLog[i])
		begin
			expAddr = (i % framesPerSample < currentFrames) ? int'(currentChannel)
				: int'(resistanceChannel);
			compareValue("frame address", int'(adcModel_inst.addrLog[i]), expAddr);
		end
		compareValue("csN low windows", adcModel_inst.burstLog.size(),
			adcModel_inst.addrLog.size() / framesPerSample);
		foreach (adcModel_inst.burstLog[i])
			compareValue("frames per csN low", adcModel_inst.burstLog[i], framesPerSample);
		compareValue("model underflows", adcModel_inst.underflows, 0);
		adcModel_inst.addrLog.delete();
		adcModel_inst.burstLog.delete();
	endtask

	initial
	begin
		seed = 23;
		errorCount = 0;
		checkCount = 0;
		testCount = 0;
		errStart = 0;
		clk = 1'b0;
		rst_n = 1'b0;
		measStart = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// idle outputs
		repeat (40)
		begin
			@(negedge clk);
			compareValue("csN", int'(csN), 1);
			compareValue("sclk", int'(sclk), 1);
			compareValue("din", int'(din), 0);
			compareValue("resultValid", int'(resultValid), 0);
			compareValue("result", int'(result), 0);
		end
		finishTest("idle after reset");

		foreach (codeSet[i])
			codeSet[i] = 3000;
		runControlCycle(943, 1234);
		finishTest("constant codes");

		repeat (2)
		begin
			fillRandom(99, 3999);
			runControlCycle(expectedCurrent(), {$random(seed)} % 4096);
		end
		finishTest("random in-range codes");

		fillOutOfRange();
		runControlCycle(int'(fallbackCode), 777);
		finishTest("out-of-range codes");

		checkFrameOrder();
		finishTest("frame addresses and csN");

		//////////////////////////////////////////////////
		// two control cycles back to back
		adcModel_inst.resistanceCode = adcCode'(2500);
		fillRandom(99, 3999);
		expFirst = expectedCurrent();
		loadCodes();
		fillRandom(0, 4095);
		expSecond = expectedCurrent();
		loadCodes();
		@(negedge clk);
		measStart = 1'b1;
		waitResult(seen);
		if (seen)
			checkResult(expFirst, 2500);
		waitResult(seen);
		measStart = 1'b0;	// before the filter sees it idle again
		if (seen)
			checkResult(expSecond, 2500);
		compareValue("codes left in model", adcModel_inst.currentQueue.size(), 0);
		checkFrameOrder();
		finishTest("back-to-back cycles");

		$display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== sources.f ====
adcPkg.sv
adcSpiMaster.sv
conversionSequencer.sv
currentScaler.sv
trimmedMeanFilter.sv
adcSampleTop.sv
adcModel.sv
tbAdcSampleTop.sv

// ==== run.sh ====
#!/bin/sh
# build and run the adcSampleTop testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sources.f --top-module tbAdcSampleTop -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/VtbAdcSampleTop)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation did not run to the end"
	exit 1
fi

if echo "$output" | grep -qx "Simulation finished: PASS"; then
	exit 0
fi
exit 1
